/* logic/tinyrv_pkg.sv */
// ----------------------------------------------------------
// tinyrv core package
// widths, opcodes, csr numbers and control encodings
// ----------------------------------------------------------

`default_nettype none

package tinyrv_pkg;

  // datapath width and fetch start
  localparam int          xlen     = 32;
  localparam logic [31:0] reset_pc = 32'h0000_0200;

  // imem requests allowed in flight
  localparam int max_inflight = 2;

  // ----------------------------------------------------------
  // instruction encodings
  // ----------------------------------------------------------

  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [2:0] f3_bne   = 3'b001;
  localparam logic [2:0] f3_csrrw = 3'b001;
  localparam logic [2:0] f3_csrrs = 3'b010;

  // manager stream csrs
  localparam logic [11:0] csr_proc2mngr = 12'h7C0;
  localparam logic [11:0] csr_mngr2proc = 12'hFC0;

  // ----------------------------------------------------------
  // ctrl to dpath selects
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    pc_plus4  = 2'd0,
    pc_branch = 2'd1
  } pc_sel_t;

  typedef enum logic [1:0] {
    op2_rf   = 2'd0,
    op2_imm  = 2'd1,
    op2_mngr = 2'd2
  } op2_sel_t;

  typedef enum logic [1:0] {
    byp_rf = 2'd0,
    byp_x  = 2'd1,
    byp_w  = 2'd2
  } byp_sel_t;

endpackage

`default_nettype wire

/* logic/bypass_queue.sv */
// ----------------------------------------------------------
// one-entry bypass queue
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module bypass_queue #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     enq_val,
  input  payload_t enq_data,
  output logic     enq_rdy,
  output logic     deq_val,
  output payload_t deq_data,
  input  logic     deq_rdy
);

  logic     full;
  payload_t entry;

  // empty queue passes the enqueue straight through
  assign enq_rdy  = !full;
  assign deq_val  = full || enq_val;
  assign deq_data = full ? entry : enq_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (full) begin
      // stored entry leaves on dequeue
      if (deq_rdy) begin
        full <= 1'b0;
      end
    end else if (enq_val && !deq_rdy) begin
      full <= 1'b1;
    end
  end

  // payload capture only when the output stalls
  always_ff @(posedge clk) begin
    if (!full && enq_val && !deq_rdy) begin
      entry <= enq_data;
    end
  end

  // no enqueue while full, the refused word stays offered
  assert property (@(posedge clk) disable iff (!rst_n)
    enq_val && !enq_rdy |=> enq_val);

endmodule

`default_nettype wire

/* logic/imem_drop_unit.sv */
// ----------------------------------------------------------
// imem drop unit
// swallows responses that belong to squashed fetches
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imem_drop_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        drop,
  input  logic                        in_val,
  input  logic [tinyrv_pkg::xlen-1:0] in_data,
  output logic                        in_rdy,
  output logic                        out_val,
  output logic [tinyrv_pkg::xlen-1:0] out_data,
  input  logic                        out_rdy
);

  import tinyrv_pkg::*;

  localparam int cnt_w = $clog2(max_inflight + 1);

  logic [cnt_w-1:0] pending;
  logic             discard;
  logic             eat;

  // pending drops turn the unit into a sink
  assign discard  = (pending != '0);
  assign eat      = discard && in_val;
  assign in_rdy   = discard ? 1'b1 : out_rdy;
  assign out_val  = in_val && !discard;
  assign out_data = in_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= '0;
    end else if (drop && !eat) begin
      pending <= pending + 1'b1;
    end else if (!drop && eat) begin
      pending <= pending - 1'b1;
    end
  end

  // more pending drops than fetches in flight means ctrl lost count
  assert property (@(posedge clk) disable iff (!rst_n)
    pending <= cnt_w'(max_inflight));

endmodule

`default_nettype wire

/* logic/proc_ctrl.sv */
// ----------------------------------------------------------
// pipeline control for the four-stage core
// valid bits, decode, stalls, squash, stream handshakes
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module proc_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  output logic                        imemreq_val,
  input  logic                        imemreq_rdy,
  input  logic                        imemresp_val,
  output logic                        imemresp_rdy,
  output logic                        drop,
  input  logic                        mngr2proc_val,
  output logic                        mngr2proc_rdy,
  output logic                        proc2mngr_val,
  input  logic                        proc2mngr_rdy,
  input  logic [tinyrv_pkg::xlen-1:0] inst_D,
  input  logic                        br_ne_X,
  output logic                        reg_en_F,
  output logic                        reg_en_D,
  output logic                        reg_en_X,
  output logic                        reg_en_W,
  output tinyrv_pkg::pc_sel_t         pc_sel_F,
  output tinyrv_pkg::op2_sel_t        op2_sel_D,
  output tinyrv_pkg::byp_sel_t        byp_sel_a_D,
  output tinyrv_pkg::byp_sel_t        byp_sel_b_D,
  output logic                        rf_wen_W,
  output logic [4:0]                  rf_waddr_W
);

  import tinyrv_pkg::*;

  localparam int cnt_w = $clog2(max_inflight + 1);

  logic             started;
  logic [cnt_w-1:0] inflight;
  logic             val_F, val_D, val_X, val_W;
  logic             squash, stall_F, stall_D, stall_X, ostall_D;
  logic             resp_take, req_fire, f_free, f_go;

  // ----------------------------------------------------------
  // decode
  // ----------------------------------------------------------

  logic [6:0] opcode_D;
  logic [2:0] funct3_D;
  logic [4:0] rd_D, rs1_D, rs2_D;
  logic       is_add_D, is_addi_D, is_bne_D, is_csrr_D, is_csrw_D, wen_D;

  assign opcode_D = inst_D[6:0];
  assign funct3_D = inst_D[14:12];
  assign rd_D     = inst_D[11:7];
  assign rs1_D    = inst_D[19:15];
  assign rs2_D    = inst_D[24:20];

  assign is_add_D  = (opcode_D == op_reg) && (funct3_D == 3'b000);
  assign is_addi_D = (opcode_D == op_imm) && (funct3_D == 3'b000);
  assign is_bne_D  = (opcode_D == op_branch) && (funct3_D == f3_bne);
  assign is_csrr_D = (opcode_D == op_system) && (funct3_D == f3_csrrs)
                     && (inst_D[31:20] == csr_mngr2proc);
  assign is_csrw_D = (opcode_D == op_system) && (funct3_D == f3_csrrw)
                     && (inst_D[31:20] == csr_proc2mngr);
  // x0 writes are dropped here
  assign wen_D     = (is_add_D || is_addi_D || is_csrr_D) && (rd_D != 5'd0);

  // csrr picks up the manager word as operand b, rs1 is x0
  assign op2_sel_D = is_csrr_D ? op2_mngr : (is_addi_D ? op2_imm : op2_rf);

  // later stage state
  logic       bne_X, csrw_X, wen_X, wen_W;
  logic [4:0] waddr_X, waddr_W;

  // ----------------------------------------------------------
  // bypass, X wins over W
  // ----------------------------------------------------------

  assign byp_sel_a_D = (val_X && wen_X && waddr_X == rs1_D) ? byp_x :
                       (val_W && wen_W && waddr_W == rs1_D) ? byp_w : byp_rf;
  assign byp_sel_b_D = (val_X && wen_X && waddr_X == rs2_D) ? byp_x :
                       (val_W && wen_W && waddr_W == rs2_D) ? byp_w : byp_rf;

  // ----------------------------------------------------------
  // stall and squash
  // ----------------------------------------------------------

  // taken bne; held in X until the redirect fetch is accepted
  assign squash  = val_X && bne_X && br_ne_X;
  assign stall_X = val_X && ((csrw_X && !proc2mngr_rdy) || (squash && !imemreq_rdy));

  assign ostall_D = is_csrr_D && !mngr2proc_val;
  assign stall_D  = val_D && !squash && (ostall_D || stall_X);

  // F slot is live while its fetch is outstanding
  assign val_F        = (inflight != '0);
  assign imemresp_rdy = val_F && (squash || !stall_D);
  assign resp_take    = imemresp_val && imemresp_rdy;
  assign stall_F      = val_F && !squash && !resp_take;
  assign f_go         = resp_take && !squash;
  assign f_free       = !val_F || resp_take;

  // no fetch before the cycle after reset
  assign imemreq_val = started && (squash || (f_free && inflight < cnt_w'(max_inflight)));
  assign req_fire    = imemreq_val && imemreq_rdy;
  assign pc_sel_F    = squash ? pc_branch : pc_plus4;

  // squashed fetch still out in memory
  assign drop = squash && val_F && !resp_take;

  // manager streams
  assign mngr2proc_rdy = val_D && is_csrr_D && !squash && !stall_X;
  assign proc2mngr_val = val_X && csrw_X;

  // register enables
  assign reg_en_F = req_fire;
  assign reg_en_D = resp_take;
  assign reg_en_X = !stall_X;
  assign reg_en_W = !stall_X;

  assign rf_wen_W   = val_W && wen_W;
  assign rf_waddr_W = waddr_W;

  // ----------------------------------------------------------
  // state
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started  <= 1'b0;
      inflight <= '0;
      val_D    <= 1'b0;
      val_X    <= 1'b0;
      val_W    <= 1'b0;
    end else begin
      started <= 1'b1;
      // a squash kills every live fetch
      if (squash) begin
        inflight <= req_fire ? cnt_w'(1) : '0;
      end else if (req_fire && !resp_take) begin
        inflight <= inflight + 1'b1;
      end else if (!req_fire && resp_take) begin
        inflight <= inflight - 1'b1;
      end
      if (!stall_D) begin
        val_D <= f_go;
      end
      if (!stall_X) begin
        val_X <= val_D && !squash && !ostall_D;
      end
      val_W <= val_X && !stall_X;
    end
  end

  // decoded fields follow the valid bits
  always_ff @(posedge clk) begin
    if (reg_en_X) begin
      bne_X   <= is_bne_D;
      csrw_X  <= is_csrw_D;
      wen_X   <= wen_D;
      waddr_X <= rd_D;
    end
    if (reg_en_W) begin
      wen_W   <= wen_X;
      waddr_W <= waddr_X;
    end
  end

  // squash overrides any stall upstream
  assert property (@(posedge clk) disable iff (!rst_n)
    !(squash && (stall_F || stall_D)));

  // drop is a one-cycle pulse per squash
  assert property (@(posedge clk) disable iff (!rst_n)
    drop |=> !drop);

endmodule

`default_nettype wire

/* logic/proc_dpath.sv */
// ----------------------------------------------------------
// datapath for the four-stage core
// pc, pipe registers, regfile, bypass, immediates, alu
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module proc_dpath (
  input  logic                        clk,
  input  logic                        rst_n,
  output logic [tinyrv_pkg::xlen-1:0] imemreq_addr,
  input  logic [tinyrv_pkg::xlen-1:0] imemresp_data,
  input  logic [tinyrv_pkg::xlen-1:0] mngr2proc_data,
  output logic [tinyrv_pkg::xlen-1:0] proc2mngr_data,
  input  logic                        reg_en_F,
  input  logic                        reg_en_D,
  input  logic                        reg_en_X,
  input  logic                        reg_en_W,
  input  tinyrv_pkg::pc_sel_t         pc_sel_F,
  input  tinyrv_pkg::op2_sel_t        op2_sel_D,
  input  tinyrv_pkg::byp_sel_t        byp_sel_a_D,
  input  tinyrv_pkg::byp_sel_t        byp_sel_b_D,
  input  logic                        rf_wen_W,
  input  logic [4:0]                  rf_waddr_W,
  output logic [tinyrv_pkg::xlen-1:0] inst_D,
  output logic                        br_ne_X
);

  import tinyrv_pkg::*;

  logic [xlen-1:0] pc_F, pc_D;
  logic [xlen-1:0] target_X, op_a_X, op_b_X, alu_X;
  logic [xlen-1:0] result_W;

  // ----------------------------------------------------------
  // fetch
  // ----------------------------------------------------------

  // pc_F is the last fetched address; starts one word early
  assign imemreq_addr = (pc_sel_F == pc_branch) ? target_X : pc_F + 32'd4;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_F <= reset_pc - 32'd4;
    end else if (reg_en_F) begin
      pc_F <= imemreq_addr;
    end
  end

  // F to D, pc follows the instruction
  always_ff @(posedge clk) begin
    if (reg_en_D) begin
      inst_D <= imemresp_data;
      pc_D   <= pc_F;
    end
  end

  // ----------------------------------------------------------
  // decode
  // ----------------------------------------------------------

  logic [xlen-1:0] rf [32];
  logic [xlen-1:0] rf_a, rf_b;
  logic [xlen-1:0] op_a_D, rs2_val_D, op_b_D;
  logic [xlen-1:0] imm_i_D, imm_b_D;

  // x0 reads as zero
  assign rf_a = (inst_D[19:15] == 5'd0) ? '0 : rf[inst_D[19:15]];
  assign rf_b = (inst_D[24:20] == 5'd0) ? '0 : rf[inst_D[24:20]];

  always_ff @(posedge clk) begin
    if (rf_wen_W && rf_waddr_W != 5'd0) begin
      rf[rf_waddr_W] <= result_W;
    end
  end

  // sign-extended immediates
  assign imm_i_D = {{20{inst_D[31]}}, inst_D[31:20]};
  assign imm_b_D = {{19{inst_D[31]}}, inst_D[31], inst_D[7],
                    inst_D[30:25], inst_D[11:8], 1'b0};

  // bypass muxes
  always_comb begin
    case (byp_sel_a_D)
      byp_x:   op_a_D = alu_X;
      byp_w:   op_a_D = result_W;
      default: op_a_D = rf_a;
    endcase
    case (byp_sel_b_D)
      byp_x:   rs2_val_D = alu_X;
      byp_w:   rs2_val_D = result_W;
      default: rs2_val_D = rf_b;
    endcase
  end

  always_comb begin
    case (op2_sel_D)
      op2_imm:  op_b_D = imm_i_D;
      op2_mngr: op_b_D = mngr2proc_data;
      default:  op_b_D = rs2_val_D;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reg_en_X) begin
      op_a_X   <= op_a_D;
      op_b_X   <= op_b_D;
      target_X <= pc_D + imm_b_D;
    end
  end

  // ----------------------------------------------------------
  // execute
  // ----------------------------------------------------------

  // one adder for add, addi and csrr
  assign alu_X          = op_a_X + op_b_X;
  assign br_ne_X        = (op_a_X != op_b_X);
  // csrw sends rs1
  assign proc2mngr_data = op_a_X;

  always_ff @(posedge clk) begin
    if (reg_en_W) begin
      result_W <= alu_X;
    end
  end

endmodule

`default_nettype wire

/* logic/proc_top.sv */
// ----------------------------------------------------------
// tinyrv four-stage core top
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module proc_top (
  input  logic                        clk,
  input  logic                        rst_n,
  output logic                        imemreq_val,
  output logic [tinyrv_pkg::xlen-1:0] imemreq_addr,
  input  logic                        imemreq_rdy,
  input  logic                        imemresp_val,
  input  logic [tinyrv_pkg::xlen-1:0] imemresp_data,
  output logic                        imemresp_rdy,
  input  logic                        mngr2proc_val,
  input  logic [tinyrv_pkg::xlen-1:0] mngr2proc_data,
  output logic                        mngr2proc_rdy,
  output logic                        proc2mngr_val,
  output logic [tinyrv_pkg::xlen-1:0] proc2mngr_data,
  input  logic                        proc2mngr_rdy
);

  import tinyrv_pkg::*;

  // request side before the queues
  logic            req_enq_val, req_enq_rdy;
  logic [xlen-1:0] req_enq_addr;
  logic            p2m_enq_val, p2m_enq_rdy;
  logic [xlen-1:0] p2m_enq_data;

  // responses past the drop unit
  logic            resp_val, resp_rdy, drop;
  logic [xlen-1:0] resp_data;

  // ctrl to dpath
  logic            reg_en_F, reg_en_D, reg_en_X, reg_en_W;
  pc_sel_t         pc_sel_F;
  op2_sel_t        op2_sel_D;
  byp_sel_t        byp_sel_a_D, byp_sel_b_D;
  logic            rf_wen_W;
  logic [4:0]      rf_waddr_W;
  logic [xlen-1:0] inst_D;
  logic            br_ne_X;

  imem_drop_unit u_drop (
    .clk (clk), .rst_n (rst_n), .drop (drop),
    .in_val (imemresp_val), .in_data (imemresp_data), .in_rdy (imemresp_rdy),
    .out_val (resp_val), .out_data (resp_data), .out_rdy (resp_rdy)
  );

  proc_ctrl u_ctrl (
    .clk (clk), .rst_n (rst_n),
    .imemreq_val (req_enq_val), .imemreq_rdy (req_enq_rdy),
    .imemresp_val (resp_val), .imemresp_rdy (resp_rdy), .drop (drop),
    .mngr2proc_val (mngr2proc_val), .mngr2proc_rdy (mngr2proc_rdy),
    .proc2mngr_val (p2m_enq_val), .proc2mngr_rdy (p2m_enq_rdy),
    .inst_D (inst_D), .br_ne_X (br_ne_X),
    .reg_en_F (reg_en_F), .reg_en_D (reg_en_D),
    .reg_en_X (reg_en_X), .reg_en_W (reg_en_W),
    .pc_sel_F (pc_sel_F), .op2_sel_D (op2_sel_D),
    .byp_sel_a_D (byp_sel_a_D), .byp_sel_b_D (byp_sel_b_D),
    .rf_wen_W (rf_wen_W), .rf_waddr_W (rf_waddr_W)
  );

  proc_dpath u_dpath (
    .clk (clk), .rst_n (rst_n),
    .imemreq_addr (req_enq_addr), .imemresp_data (resp_data),
    .mngr2proc_data (mngr2proc_data), .proc2mngr_data (p2m_enq_data),
    .reg_en_F (reg_en_F), .reg_en_D (reg_en_D),
    .reg_en_X (reg_en_X), .reg_en_W (reg_en_W),
    .pc_sel_F (pc_sel_F), .op2_sel_D (op2_sel_D),
    .byp_sel_a_D (byp_sel_a_D), .byp_sel_b_D (byp_sel_b_D),
    .rf_wen_W (rf_wen_W), .rf_waddr_W (rf_waddr_W),
    .inst_D (inst_D), .br_ne_X (br_ne_X)
  );

  // outgoing streams, one entry each
  bypass_queue #(.payload_t (logic [xlen-1:0])) u_imemreq_q (
    .clk (clk), .rst_n (rst_n),
    .enq_val (req_enq_val), .enq_data (req_enq_addr), .enq_rdy (req_enq_rdy),
    .deq_val (imemreq_val), .deq_data (imemreq_addr), .deq_rdy (imemreq_rdy)
  );

  bypass_queue #(.payload_t (logic [xlen-1:0])) u_proc2mngr_q (
    .clk (clk), .rst_n (rst_n),
    .enq_val (p2m_enq_val), .enq_data (p2m_enq_data), .enq_rdy (p2m_enq_rdy),
    .deq_val (proc2mngr_val), .deq_data (proc2mngr_data), .deq_rdy (proc2mngr_rdy)
  );

endmodule

`default_nettype wire

/* tests/proc_tb.sv */
// ----------------------------------------------------------
// testbench for the tinyrv four-stage core
// imem model, manager source and sink, directed tests
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module proc_tb;

  import tinyrv_pkg::*;

  logic        clk;
  logic        rst_n          = 1'b0;
  logic        imemreq_val;
  logic [31:0] imemreq_addr;
  logic        imemreq_rdy    = 1'b1;
  logic        imemresp_val   = 1'b0;
  logic [31:0] imemresp_data  = '0;
  logic        imemresp_rdy;
  logic        mngr2proc_val  = 1'b0;
  logic [31:0] mngr2proc_data = '0;
  logic        mngr2proc_rdy;
  logic        proc2mngr_val;
  logic [31:0] proc2mngr_data;
  logic        proc2mngr_rdy  = 1'b0;

  // test build lists, copied into the live lists during reset
  logic [31:0] prog_q[$];
  logic [31:0] in_q[$];
  logic [31:0] want_q[$];
  logic [31:0] arith_prog[$];
  logic [31:0] arith_in[$];
  logic [31:0] arith_want[$];
  logic [31:0] exp_q[$];
  logic [31:0] src_q[$];

  // imem model state
  logic [31:0] imem [256];
  logic [31:0] pend_addr[$];
  int unsigned pend_edge[$];
  int unsigned edge_count = 0;

  int          out_count  = 0;
  int          mngr_taken = 0;
  int          hold_left  = 0;
  bit          slow_sink  = 1'b0;
  int unsigned seed_word;

  proc_top DUT (
    .clk (clk), .rst_n (rst_n),
    .imemreq_val (imemreq_val), .imemreq_addr (imemreq_addr), .imemreq_rdy (imemreq_rdy),
    .imemresp_val (imemresp_val), .imemresp_data (imemresp_data),
    .imemresp_rdy (imemresp_rdy),
    .mngr2proc_val (mngr2proc_val), .mngr2proc_data (mngr2proc_data),
    .mngr2proc_rdy (mngr2proc_rdy),
    .proc2mngr_val (proc2mngr_val), .proc2mngr_data (proc2mngr_data),
    .proc2mngr_rdy (proc2mngr_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------------------------
  // failure reporting and checks
  // ----------------------------------------------------------

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("Error: time %0t, %s expected %h, got %h", $time, name, want, got);
      abort_run();
    end
  endtask

  // ----------------------------------------------------------
  // instruction encoders
  // ----------------------------------------------------------

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, op_imm};
  endfunction

  function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {7'b0, rs2, rs1, 3'b000, rd, op_reg};
  endfunction

  // off is the byte offset from the bne itself
  function automatic logic [31:0] enc_bne(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3_bne, off[4:1], off[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_csrr(input logic [4:0] rd);
    return {csr_mngr2proc, 5'd0, f3_csrrs, rd, op_system};
  endfunction

  function automatic logic [31:0] enc_csrw(input logic [4:0] rs1);
    return {csr_proc2mngr, rs1, f3_csrrw, 5'd0, op_system};
  endfunction

  // unused words hold addi x0 with an address hash, harmless nops
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[11:0] ^ addr[23:12] ^ {4'b0, addr[31:24]}, 5'd0, 3'b000, 5'd0, op_imm};
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr[31:10] == '0) begin
      return imem[addr[9:2]];
    end
    return fill_word(addr);
  endfunction

  // ----------------------------------------------------------
  // imem model, manager source and sink
  // ----------------------------------------------------------

  // in-order responses, 0 to 3 cycles of extra delay
  always @(posedge clk) begin
    if (!rst_n) begin
      pend_addr.delete();
      pend_edge.delete();
      imemresp_val <= 1'b0;
    end else begin
      if (imemresp_val && imemresp_rdy) begin
        pend_addr.delete(0);
        pend_edge.delete(0);
      end
      if (imemreq_val && imemreq_rdy) begin
        pend_addr.push_back(imemreq_addr);
        pend_edge.push_back(edge_count + ($urandom % 4));
      end
      if (pend_addr.size() != 0 && pend_edge[0] <= edge_count) begin
        imemresp_val  <= 1'b1;
        imemresp_data <= fetch_word(pend_addr[0]);
      end else begin
        imemresp_val <= 1'b0;
      end
    end
    edge_count <= edge_count + 1;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      mngr2proc_val <= 1'b0;
      mngr_taken    <= 0;
    end else begin
      if (mngr2proc_val && mngr2proc_rdy) begin
        src_q.delete(0);
        mngr_taken <= mngr_taken + 1;
      end
      mngr2proc_val <= (src_q.size() != 0);
      if (src_q.size() != 0) begin
        mngr2proc_data <= src_q[0];
      end
    end
  end

  // every word out is checked against the expected list in order
  always @(posedge clk) begin
    if (!rst_n) begin
      proc2mngr_rdy <= 1'b0;
      out_count     <= 0;
      hold_left     <= 0;
    end else begin
      if (proc2mngr_val && proc2mngr_rdy) begin
        if (out_count < exp_q.size()) begin
          check_value("proc2mngr_data", proc2mngr_data, exp_q[out_count]);
        end else begin
          $display("proc2mngr sent a word beyond the expected list at time %0t", $time);
          abort_run();
        end
        out_count <= out_count + 1;
      end
      if (!slow_sink) begin
        proc2mngr_rdy <= 1'($urandom % 2);
      end else if (hold_left == 0) begin
        // long low stretches, short bursts of ready
        proc2mngr_rdy <= !proc2mngr_rdy;
        hold_left     <= proc2mngr_rdy ? 12 + int'($urandom % 20) : int'($urandom % 3);
      end else begin
        hold_left <= hold_left - 1;
      end
    end
  end

  // ----------------------------------------------------------
  // run control
  // ----------------------------------------------------------

  task automatic clear_lists();
    prog_q.delete();
    in_q.delete();
    want_q.delete();
  endtask

  task automatic load_program(input bit slow);
    int i;
    for (i = 0; i < 256; i++) begin
      imem[i] = fill_word(32'(i) << 2);
    end
    for (i = 0; i < prog_q.size(); i++) begin
      imem[reset_pc[9:2] + 8'(i)] = prog_q[i];
    end
    src_q     = in_q;
    exp_q     = want_q;
    slow_sink = slow;
  endtask

  // 16 reset cycles, outputs quiet until the first fetch
  task automatic apply_reset(input bit slow);
    int k;
    int waited;
    @(posedge clk);
    rst_n <= 1'b0;
    @(posedge clk);
    load_program(slow);
    for (k = 2; k <= 17; k++) begin
      @(posedge clk);
      if (k == 16) begin
        rst_n <= 1'b1;
      end
      check_value("imemreq_val", 32'(imemreq_val), 32'd0);
      check_value("imemresp_rdy", 32'(imemresp_rdy), 32'd0);
      check_value("proc2mngr_val", 32'(proc2mngr_val), 32'd0);
      check_value("mngr2proc_rdy", 32'(mngr2proc_rdy), 32'd0);
    end
    waited = 0;
    while (!imemreq_val) begin
      @(posedge clk);
      waited++;
      if (waited > 8) begin
        $display("timeout: no instruction fetch after reset");
        abort_run();
      end
    end
    check_value("imemreq_addr", imemreq_addr, reset_pc);
  endtask

  task automatic run_program(input bit slow);
    int waited;
    int k;
    apply_reset(slow);
    waited = 0;
    while (out_count < exp_q.size()) begin
      @(posedge clk);
      waited++;
      if (waited > 5000) begin
        $display("timeout: proc2mngr gave %0d of %0d words", out_count, exp_q.size());
        abort_run();
      end
    end
    // quiet window, any stray word shows up in the sink
    for (k = 0; k < 40; k++) begin
      @(posedge clk);
    end
    check_value("mngr2proc word count", 32'(mngr_taken), 32'(in_q.size()));
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------

  task automatic test_echo();
    int i;
    int n;
    logic [31:0] w;
    clear_lists();
    n = 4 + int'($urandom % 5);
    prog_q.push_back(enc_addi(5'd2, 5'd0, 12'd1));
    prog_q.push_back(enc_csrr(5'd1));
    prog_q.push_back(enc_csrw(5'd1));
    prog_q.push_back(enc_bne(5'd2, 5'd0, -13'sd8));
    for (i = 0; i < n; i++) begin
      w = $urandom;
      in_q.push_back(w);
      want_q.push_back(w);
    end
    run_program(1'b0);
  endtask

  // dependent chain, sums kept in a register model with 32-bit wrap
  task automatic test_arith();
    logic [31:0] regs [32];
    logic [11:0] imm;
    logic [4:0]  rd;
    logic [4:0]  prev;
    logic [4:0]  prev2;
    int i;
    clear_lists();
    regs[1] = 32'hFFFF_FF00 | ($urandom & 32'hFF);
    regs[2] = $urandom;
    prog_q.push_back(enc_csrr(5'd1));
    prog_q.push_back(enc_csrr(5'd2));
    in_q.push_back(regs[1]);
    in_q.push_back(regs[2]);
    prev  = 5'd1;
    prev2 = 5'd2;
    for (i = 0; i < 12; i++) begin
      rd = 5'd3 + 5'(i % 5);
      if (i % 2 == 0) begin
        imm = 12'($urandom);
        prog_q.push_back(enc_addi(rd, prev, imm));
        regs[rd] = regs[prev] + {{20{imm[11]}}, imm};
      end else begin
        prog_q.push_back(enc_add(rd, prev, prev2));
        regs[rd] = regs[prev] + regs[prev2];
      end
      // some results only feed the next op
      if (i % 3 != 2) begin
        prog_q.push_back(enc_csrw(rd));
        want_q.push_back(regs[rd]);
      end
      prev2 = prev;
      prev  = rd;
    end
    arith_prog = prog_q;
    arith_in   = in_q;
    arith_want = want_q;
    run_program(1'b0);
  endtask

  // countdown loop, csrw after each bne is on the fall-through path
  task automatic test_branch();
    int n;
    int k;
    clear_lists();
    n = 3 + int'($urandom % 6);
    prog_q.push_back(enc_addi(5'd1, 5'd0, 12'(n)));
    prog_q.push_back(enc_addi(5'd2, 5'd0, 12'd0));
    prog_q.push_back(enc_addi(5'd3, 5'd0, 12'd1));
    prog_q.push_back(enc_addi(5'd1, 5'd1, 12'hFFF));
    prog_q.push_back(enc_csrw(5'd1));
    prog_q.push_back(enc_addi(5'd2, 5'd2, 12'd1));
    prog_q.push_back(enc_bne(5'd1, 5'd0, -13'sd12));
    prog_q.push_back(enc_csrw(5'd2));
    // spin in place forever
    prog_q.push_back(enc_bne(5'd3, 5'd0, 13'd0));
    prog_q.push_back(enc_csrw(5'd3));
    for (k = n - 1; k >= 0; k--) begin
      want_q.push_back(32'(k));
    end
    want_q.push_back(32'(n));
    run_program(1'b0);
  endtask

  task automatic test_backpressure();
    prog_q = arith_prog;
    in_q   = arith_in;
    want_q = arith_want;
    run_program(1'b1);
  endtask

  initial begin
    seed_word = $urandom(32'h194375e6);
    test_echo();
    test_arith();
    test_branch();
    test_backpressure();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
logic/tinyrv_pkg.sv
logic/bypass_queue.sv
logic/imem_drop_unit.sv
logic/proc_ctrl.sv
logic/proc_dpath.sv
logic/proc_top.sv
tests/proc_tb.sv

/* Bender.yml */
package:
  name: tinyrv_core

sources:
  - logic/tinyrv_pkg.sv
  - logic/bypass_queue.sv
  - logic/imem_drop_unit.sv
  - logic/proc_ctrl.sv
  - logic/proc_dpath.sv
  - logic/proc_top.sv
  - target: test
    files:
      - tests/proc_tb.sv
